// File: rtl/id_pkg.sv
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;
    localparam int ALU_SEL_W  = 3;

    localparam logic [REG_ADDR_W-1:0] NOP_REG_ADDR = 5'd0;  // $zero

    // major opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_PREF    = 6'b110011;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;

    // SPECIAL funct field, inst[5:0]
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SYNC = 6'b001111;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_MOVZ = 6'b001010;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;

    // alu operations seen by EX
    localparam logic [ALU_OP_W-1:0] ALU_NOP   = 8'b00000000;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 8'b00100101;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 8'b00100100;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 8'b00100110;
    localparam logic [ALU_OP_W-1:0] ALU_NOR   = 8'b00100111;
    localparam logic [ALU_OP_W-1:0] ALU_LUI   = 8'b01011100;
    localparam logic [ALU_OP_W-1:0] ALU_SLL   = 8'b01111100;
    localparam logic [ALU_OP_W-1:0] ALU_SRL   = 8'b00000010;
    localparam logic [ALU_OP_W-1:0] ALU_SRA   = 8'b00000011;
    localparam logic [ALU_OP_W-1:0] ALU_SLLV  = 8'b00000100;
    localparam logic [ALU_OP_W-1:0] ALU_SRLV  = 8'b00000110;
    localparam logic [ALU_OP_W-1:0] ALU_SRAV  = 8'b00000111;
    localparam logic [ALU_OP_W-1:0] ALU_MOVN  = 8'b00001011;
    localparam logic [ALU_OP_W-1:0] ALU_MOVZ  = 8'b00001010;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 8'b00101010;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 8'b00101011;
    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 8'b00100000;
    localparam logic [ALU_OP_W-1:0] ALU_ADDU  = 8'b00100001;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 8'b00100010;
    localparam logic [ALU_OP_W-1:0] ALU_SUBU  = 8'b00100011;
    localparam logic [ALU_OP_W-1:0] ALU_ADDI  = 8'b01010101;
    localparam logic [ALU_OP_W-1:0] ALU_ADDIU = 8'b01010110;

    // result class, picks the EX result mux leg
    localparam logic [ALU_SEL_W-1:0] SEL_NOP   = 3'b000;
    localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'b001;
    localparam logic [ALU_SEL_W-1:0] SEL_SHIFT = 3'b010;
    localparam logic [ALU_SEL_W-1:0] SEL_MOVE  = 3'b011;
    localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'b100;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } inst_i_t;

    // same 32-bit word, R or I view
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

endpackage

// File: rtl/inst_decode.sv
`timescale 1ns/1ns

module inst_decode
    import id_pkg::*;
(
    input  inst_t                 inst_i,
    input  logic [DATA_W-1:0]     rt_value_i,   // resolved rt, for movn/movz
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output logic [REG_ADDR_W-1:0] reg1_addr_o,
    output logic [REG_ADDR_W-1:0] reg2_addr_o,
    output logic [ALU_OP_W-1:0]   aluop_o,
    output logic [ALU_SEL_W-1:0]  alusel_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output logic                  inst_valid_o,
    output logic [DATA_W-1:0]     imm_o
);

    always_comb begin
        reg1_read_o  = 1'b0;
        reg2_read_o  = 1'b0;
        reg1_addr_o  = inst_i.r.rs;
        reg2_addr_o  = inst_i.r.rt;
        aluop_o      = ALU_NOP;
        alusel_o     = SEL_NOP;
        wd_o         = inst_i.r.rd;
        wreg_o       = 1'b0;
        inst_valid_o = 1'b0;
        imm_o        = '0;

        case (inst_i.i.opcode)
            OP_SPECIAL: begin
                if (inst_i.r.shamt == 5'd0) begin
                    // register-register forms, rd destination
                    reg1_read_o  = 1'b1;
                    reg2_read_o  = 1'b1;
                    wreg_o       = 1'b1;
                    inst_valid_o = 1'b1;
                    case (inst_i.r.funct)
                        FN_AND:  aluop_o = ALU_AND;
                        FN_OR:   aluop_o = ALU_OR;
                        FN_XOR:  aluop_o = ALU_XOR;
                        FN_NOR:  aluop_o = ALU_NOR;
                        FN_SLLV: aluop_o = ALU_SLLV;
                        FN_SRLV: aluop_o = ALU_SRLV;
                        FN_SRAV: aluop_o = ALU_SRAV;
                        FN_SLT:  aluop_o = ALU_SLT;
                        FN_SLTU: aluop_o = ALU_SLTU;
                        FN_ADD:  aluop_o = ALU_ADD;
                        FN_ADDU: aluop_o = ALU_ADDU;
                        FN_SUB:  aluop_o = ALU_SUB;
                        FN_SUBU: aluop_o = ALU_SUBU;
                        FN_MOVN: begin
                            aluop_o = ALU_MOVN;
                            wreg_o  = (rt_value_i != '0);
                        end
                        FN_MOVZ: begin
                            aluop_o = ALU_MOVZ;
                            wreg_o  = (rt_value_i == '0);
                        end
                        FN_SYNC: begin  // no-op, nothing read or written
                            reg1_read_o = 1'b0;
                            reg2_read_o = 1'b0;
                            wreg_o      = 1'b0;
                        end
                        default: begin
                            reg1_read_o  = 1'b0;
                            reg2_read_o  = 1'b0;
                            wreg_o       = 1'b0;
                            inst_valid_o = 1'b0;
                        end
                    endcase
                    case (inst_i.r.funct)
                        FN_AND, FN_OR, FN_XOR, FN_NOR:    alusel_o = SEL_LOGIC;
                        FN_SLLV, FN_SRLV, FN_SRAV:        alusel_o = SEL_SHIFT;
                        FN_MOVN, FN_MOVZ:                 alusel_o = SEL_MOVE;
                        FN_SLT, FN_SLTU, FN_ADD, FN_ADDU,
                        FN_SUB, FN_SUBU:                  alusel_o = SEL_ARITH;
                        default:                          alusel_o = SEL_NOP;
                    endcase
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                // rs op imm -> rt
                reg1_read_o  = 1'b1;
                wd_o         = inst_i.i.rt;
                wreg_o       = 1'b1;
                inst_valid_o = 1'b1;
                case (inst_i.i.opcode)
                    OP_ORI:   aluop_o = ALU_OR;
                    OP_ANDI:  aluop_o = ALU_AND;
                    OP_XORI:  aluop_o = ALU_XOR;
                    OP_LUI:   aluop_o = ALU_LUI;
                    OP_SLTI:  aluop_o = ALU_SLT;
                    OP_SLTIU: aluop_o = ALU_SLTU;
                    OP_ADDI:  aluop_o = ALU_ADDI;
                    default:  aluop_o = ALU_ADDIU;
                endcase
                if (inst_i.i.opcode inside {OP_ORI, OP_ANDI, OP_XORI}) begin
                    alusel_o = SEL_LOGIC;
                    imm_o    = {16'h0000, inst_i.i.imm16};
                end else if (inst_i.i.opcode == OP_LUI) begin
                    alusel_o = SEL_LOGIC;
                    imm_o    = {inst_i.i.imm16, 16'h0000};
                end else begin
                    alusel_o = SEL_ARITH;
                    imm_o    = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
                end
            end
            OP_PREF: inst_valid_o = 1'b1;  // hint only
            default: ;
        endcase

        // shift-by-shamt forms need rs == 0, shamt is free
        if (inst_i.r.opcode == OP_SPECIAL && inst_i.r.rs == 5'd0 &&
            inst_i.r.funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
            reg1_read_o  = 1'b0;    // reg1 takes the shift amount
            reg2_read_o  = 1'b1;
            alusel_o     = SEL_SHIFT;
            wd_o         = inst_i.r.rd;
            wreg_o       = 1'b1;
            inst_valid_o = 1'b1;
            imm_o        = {27'd0, inst_i.r.shamt};
            case (inst_i.r.funct)
                FN_SLL:  aluop_o = ALU_SLL;
                FN_SRL:  aluop_o = ALU_SRL;
                default: aluop_o = ALU_SRA;
            endcase
        end
    end

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/1ns

module operand_select
    import id_pkg::*;
(
    input  logic                  read_i,
    input  logic [REG_ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0]     reg_data_i,
    input  logic [DATA_W-1:0]     imm_i,
    input  logic                  ex_wreg_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [DATA_W-1:0]     ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [DATA_W-1:0]     mem_wdata_i,
    output logic [DATA_W-1:0]     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // youngest producer wins, $zero is not special-cased
    assign ex_hit  = read_i && ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = read_i && mem_wreg_i && (mem_wd_i == addr_i);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_wdata_i;
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else if (read_i) begin
            operand_o = reg_data_i;
        end else begin
            operand_o = imm_i;  // port unused by the instruction
        end
    end

endmodule

// File: rtl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [ALU_OP_W-1:0]   aluop_i,
    input  logic [ALU_SEL_W-1:0]  alusel_i,
    input  logic [DATA_W-1:0]     reg1_i,
    input  logic [DATA_W-1:0]     reg2_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic                  wreg_i,
    input  logic                  inst_valid_i,
    output logic [ALU_OP_W-1:0]   ex_aluop_o,
    output logic [ALU_SEL_W-1:0]  ex_alusel_o,
    output logic [DATA_W-1:0]     ex_reg1_o,
    output logic [DATA_W-1:0]     ex_reg2_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o,
    output logic                  ex_inst_valid_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // EX sees a bubble
            ex_aluop_o      <= ALU_NOP;
            ex_alusel_o     <= SEL_NOP;
            ex_reg1_o       <= '0;
            ex_reg2_o       <= '0;
            ex_wd_o         <= NOP_REG_ADDR;
            ex_wreg_o       <= 1'b0;
            ex_inst_valid_o <= 1'b0;
        end else begin
            ex_aluop_o      <= aluop_i;
            ex_alusel_o     <= alusel_i;
            ex_reg1_o       <= reg1_i;
            ex_reg2_o       <= reg2_i;
            ex_wd_o         <= wd_i;
            ex_wreg_o       <= wreg_i;
            ex_inst_valid_o <= inst_valid_i;
        end
    end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  inst_t                 inst_i,
    input  logic [DATA_W-1:0]     reg1_data_i,
    input  logic [DATA_W-1:0]     reg2_data_i,
    input  logic                  ex_wreg_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [DATA_W-1:0]     ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [DATA_W-1:0]     mem_wdata_i,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output logic [REG_ADDR_W-1:0] reg1_addr_o,
    output logic [REG_ADDR_W-1:0] reg2_addr_o,
    output logic [ALU_OP_W-1:0]   ex_aluop_o,
    output logic [ALU_SEL_W-1:0]  ex_alusel_o,
    output logic [DATA_W-1:0]     ex_reg1_o,
    output logic [DATA_W-1:0]     ex_reg2_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o,
    output logic                  ex_inst_valid_o
);

    logic [ALU_OP_W-1:0]   aluop;
    logic [ALU_SEL_W-1:0]  alusel;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic                  inst_valid;
    logic [DATA_W-1:0]     imm;
    logic [DATA_W-1:0]     reg1;
    logic [DATA_W-1:0]     reg2;   // also feeds movn/movz test

    inst_decode u_decode (
        .inst_i       (inst_i),
        .rt_value_i   (reg2),
        .reg1_read_o  (reg1_read_o),
        .reg2_read_o  (reg2_read_o),
        .reg1_addr_o  (reg1_addr_o),
        .reg2_addr_o  (reg2_addr_o),
        .aluop_o      (aluop),
        .alusel_o     (alusel),
        .wd_o         (wd),
        .wreg_o       (wreg),
        .inst_valid_o (inst_valid),
        .imm_o        (imm)
    );

    operand_select u_sel1 (
        .read_i      (reg1_read_o),
        .addr_i      (reg1_addr_o),
        .reg_data_i  (reg1_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1)
    );

    operand_select u_sel2 (
        .read_i      (reg2_read_o),
        .addr_i      (reg2_addr_o),
        .reg_data_i  (reg2_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2)
    );

    id_ex_reg u_id_ex (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .aluop_i         (aluop),
        .alusel_i        (alusel),
        .reg1_i          (reg1),
        .reg2_i          (reg2),
        .wd_i            (wd),
        .wreg_i          (wreg),
        .inst_valid_i    (inst_valid),
        .ex_aluop_o      (ex_aluop_o),
        .ex_alusel_o     (ex_alusel_o),
        .ex_reg1_o       (ex_reg1_o),
        .ex_reg2_o       (ex_reg2_o),
        .ex_wd_o         (ex_wd_o),
        .ex_wreg_o       (ex_wreg_o),
        .ex_inst_valid_o (ex_inst_valid_o)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_o);
        arst_n_o = 1'b1;    // released on a falling edge
    end

endmodule

// File: bench/id_stage_tb.sv
`timescale 1ns/1ns

module id_stage_tb
    import id_pkg::*;
();

    localparam int          CLK_PERIOD     = 40;
    localparam int          RESET_CYCLES   = 16;
    localparam int          SPARE_CYCLES   = 10;
    localparam int          WORDS_PER_CASE = 19;
    localparam int          MAX_CASES      = 64;
    localparam logic [31:0] END_MARK       = 32'hffff_ffff;
    localparam string       CASE_FILE      = "bench/id_cases.mem";

    logic                  clk;
    logic                  arst_n;
    inst_t                 inst;
    logic [DATA_W-1:0]     reg1_data;
    logic [DATA_W-1:0]     reg2_data;
    logic                  ex_wreg;
    logic [REG_ADDR_W-1:0] ex_wd;
    logic [DATA_W-1:0]     ex_wdata;
    logic                  mem_wreg;
    logic [REG_ADDR_W-1:0] mem_wd;
    logic [DATA_W-1:0]     mem_wdata;
    logic                  reg1_read;
    logic                  reg2_read;
    logic [REG_ADDR_W-1:0] reg1_addr;
    logic [REG_ADDR_W-1:0] reg2_addr;
    logic [ALU_OP_W-1:0]   ex_aluop;
    logic [ALU_SEL_W-1:0]  ex_alusel;
    logic [DATA_W-1:0]     ex_reg1;
    logic [DATA_W-1:0]     ex_reg2;
    logic [REG_ADDR_W-1:0] ex_wd_out;
    logic                  ex_wreg_out;
    logic                  ex_inst_valid;

    // expected values of the case on the inputs
    logic                  exp_read1;
    logic                  exp_read2;
    logic [ALU_OP_W-1:0]   exp_aluop;
    logic [ALU_SEL_W-1:0]  exp_alusel;
    logic [DATA_W-1:0]     exp_reg1;
    logic [DATA_W-1:0]     exp_reg2;
    logic [REG_ADDR_W-1:0] exp_wd;
    logic                  exp_wreg;
    logic                  exp_valid;

    logic [31:0] case_words [0:MAX_CASES*WORDS_PER_CASE-1];
    int          n_cases;
    int          err_count;
    int          check_count;
    integer      seed;
    bit          loaded;
    string       where;

    tb_clock #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    id_stage dut_i (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .inst_i          (inst),
        .reg1_data_i     (reg1_data),
        .reg2_data_i     (reg2_data),
        .ex_wreg_i       (ex_wreg),
        .ex_wd_i         (ex_wd),
        .ex_wdata_i      (ex_wdata),
        .mem_wreg_i      (mem_wreg),
        .mem_wd_i        (mem_wd),
        .mem_wdata_i     (mem_wdata),
        .reg1_read_o     (reg1_read),
        .reg2_read_o     (reg2_read),
        .reg1_addr_o     (reg1_addr),
        .reg2_addr_o     (reg2_addr),
        .ex_aluop_o      (ex_aluop),
        .ex_alusel_o     (ex_alusel),
        .ex_reg1_o       (ex_reg1),
        .ex_reg2_o       (ex_reg2),
        .ex_wd_o         (ex_wd_out),
        .ex_wreg_o       (ex_wreg_out),
        .ex_inst_valid_o (ex_inst_valid)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("MISMATCH %0t ns %s %s: expected %h, got %h",
                     $time, where, name, expected, actual);
        end
    endtask

    // EX first, then MEM, then the register file, else the immediate
    function automatic logic [31:0] predict_operand(input logic read,
            input logic [4:0] addr, input logic [31:0] reg_val, input logic [31:0] imm);
        if (read && ex_wreg && ex_wd == addr) begin
            return ex_wdata;
        end else if (read && mem_wreg && mem_wd == addr) begin
            return mem_wdata;
        end else if (read) begin
            return reg_val;
        end else begin
            return imm;
        end
    endfunction

    task automatic apply_case(input int k);
        int          base;
        logic [31:0] flags;
        base       = k * WORDS_PER_CASE;
        flags      = case_words[base];
        inst       = case_words[base + 1];
        reg1_data  = flags[0] ? $random(seed) : case_words[base + 2];
        reg2_data  = flags[1] ? $random(seed) : case_words[base + 3];
        ex_wreg    = case_words[base + 4][0];
        ex_wd      = case_words[base + 5][4:0];
        ex_wdata   = case_words[base + 6];
        mem_wreg   = case_words[base + 7][0];
        mem_wd     = case_words[base + 8][4:0];
        mem_wdata  = case_words[base + 9];
        exp_read1  = case_words[base + 10][0];
        exp_read2  = case_words[base + 11][0];
        exp_aluop  = case_words[base + 12][7:0];
        exp_alusel = case_words[base + 13][2:0];
        exp_reg1   = case_words[base + 14];
        exp_reg2   = case_words[base + 15];
        exp_wd     = case_words[base + 16][4:0];
        exp_wreg   = case_words[base + 17][0];
        exp_valid  = case_words[base + 18][0];
        // random register data, operand follows the forwarding rule
        if (flags[0]) begin
            exp_reg1 = predict_operand(exp_read1, inst.r.rs, reg1_data, exp_reg1);
        end
        if (flags[1]) begin
            exp_reg2 = predict_operand(exp_read2, inst.r.rt, reg2_data, exp_reg2);
        end
    endtask

    task automatic check_read_ports();
        check_value("reg1_read_o", 32'(reg1_read), 32'(exp_read1));
        check_value("reg2_read_o", 32'(reg2_read), 32'(exp_read2));
        check_value("reg1_addr_o", 32'(reg1_addr), 32'(inst.r.rs));
        check_value("reg2_addr_o", 32'(reg2_addr), 32'(inst.r.rt));
    endtask

    task automatic check_ex_outputs();
        check_value("ex_aluop_o", 32'(ex_aluop), 32'(exp_aluop));
        check_value("ex_alusel_o", 32'(ex_alusel), 32'(exp_alusel));
        check_value("ex_reg1_o", ex_reg1, exp_reg1);
        check_value("ex_reg2_o", ex_reg2, exp_reg2);
        check_value("ex_wd_o", 32'(ex_wd_out), 32'(exp_wd));
        check_value("ex_wreg_o", 32'(ex_wreg_out), 32'(exp_wreg));
        check_value("ex_inst_valid_o", 32'(ex_inst_valid), 32'(exp_valid));
    endtask

    task automatic check_reset_state();
        check_value("ex_aluop_o", 32'(ex_aluop), 32'(ALU_NOP));
        check_value("ex_alusel_o", 32'(ex_alusel), 32'(SEL_NOP));
        check_value("ex_reg1_o", ex_reg1, 32'h0);
        check_value("ex_reg2_o", ex_reg2, 32'h0);
        check_value("ex_wd_o", 32'(ex_wd_out), 32'h0);
        check_value("ex_wreg_o", 32'(ex_wreg_out), 32'h0);
        check_value("ex_inst_valid_o", 32'(ex_inst_valid), 32'h0);
    endtask

    initial begin
        int k;
        seed        = 32'haf19592a;
        err_count   = 0;
        check_count = 0;
        loaded      = 1'b0;
        where       = "reset";
        inst        = '0;
        reg1_data   = '0;
        reg2_data   = '0;
        ex_wreg     = 1'b0;
        ex_wd       = '0;
        ex_wdata    = '0;
        mem_wreg    = 1'b0;
        mem_wd      = '0;
        mem_wdata   = '0;
        for (k = 0; k < MAX_CASES * WORDS_PER_CASE; k++) begin
            case_words[k] = END_MARK;
        end
        $readmemh(CASE_FILE, case_words);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_words[n_cases * WORDS_PER_CASE] != END_MARK) begin
            n_cases++;
        end
        loaded = 1'b1;
        if (n_cases == 0) begin
            $display("no test cases could be read from %s", CASE_FILE);
            err_count++;
        end

        repeat (4) @(negedge clk);
        check_reset_state();
        wait (arst_n);
        #1;
        where = "after reset";
        check_reset_state();     // no edge yet since release

        @(negedge clk);
        for (k = 0; k < n_cases; k++) begin
            where = $sformatf("case %0d", k);
            apply_case(k);
            #1;
            check_read_ports();
            @(negedge clk);      // one rising edge later
            check_ex_outputs();
        end

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #((n_cases + RESET_CYCLES + SPARE_CYCLES) * CLK_PERIOD);
        $display("run timed out after %0d cycles without finishing the cases",
                 n_cases + RESET_CYCLES + SPARE_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: bench/id_cases.mem
// flags inst reg1_data reg2_data ex_wreg ex_wd ex_wdata mem_wreg mem_wd mem_wdata, then expected
// read1 read2 aluop alusel reg1 reg2 wd wreg valid; flags bit0/bit1 = random reg1/reg2 data
// logic and immediates
0 34238001 12345678 aaaaaaaa 0 00 00000000 0 00 00000000 1 0 25 1 12345678 00008001 03 1 1
1 3044f0f0 00000000 00000000 1 07 11111111 0 00 00000000 1 0 24 1 00000000 0000f0f0 04 1 1
0 38c500ff 0f0f0f0f 00000000 0 00 00000000 0 00 00000000 1 0 26 1 0f0f0f0f 000000ff 05 1 1
0 3c07abcd 00000000 00000000 0 00 00000000 0 00 00000000 1 0 5c 1 00000000 abcd0000 07 1 1
0 012a4024 55555555 33333333 0 00 00000000 1 1f 77777777 1 1 24 1 55555555 33333333 08 1 1
3 018d5825 00000000 00000000 0 00 00000000 0 00 00000000 1 1 25 1 00000000 00000000 0b 1 1
// shifts, then a bad shamt and the all-zero word
0 00831004 0000001f 80000001 0 00 00000000 0 00 00000000 1 1 04 2 0000001f 80000001 02 1 1
3 00e62806 00000000 00000000 0 00 00000000 0 00 00000000 1 1 06 2 00000000 00000000 05 1 1
0 000b5140 deadbeef 00000003 1 00 99999999 0 00 00000000 0 1 7c 2 00000005 00000003 0a 1 1
0 000d67c2 00000000 80000000 0 00 00000000 0 00 00000000 0 1 02 2 0000001f 80000000 0c 1 1
2 000f7043 00000000 00000000 0 00 00000000 0 00 00000000 0 1 03 2 00000001 00000000 0e 1 1
0 002218e0 13579bdf 2468ace0 1 01 99999999 0 00 00000000 0 0 00 0 00000000 00000000 03 0 0
0 00000000 a5a5a5a5 5a5a5a5a 0 00 00000000 0 00 00000000 0 1 7c 2 00000000 5a5a5a5a 00 1 1
// arithmetic
0 2062fffc 00000010 00000000 0 00 00000000 0 00 00000000 1 0 55 4 00000010 fffffffc 02 1 1
1 24a47fff 00000000 00000000 0 00 00000000 1 05 44444444 1 0 56 4 00000000 00007fff 04 1 1
0 28e68000 80000000 00000000 0 00 00000000 0 00 00000000 1 0 2a 4 80000000 ffff8000 06 1 1
0 2d28ffff 00000001 00000000 0 00 00000000 0 00 00000000 1 0 2b 4 00000001 ffffffff 08 1 1
0 00430820 7fffffff 00000001 0 00 00000000 0 00 00000000 1 1 20 4 7fffffff 00000001 01 1 1
3 00a62021 00000000 00000000 1 06 66666666 0 00 00000000 1 1 21 4 00000000 00000000 04 1 1
0 01093822 00000005 00000007 0 00 00000000 0 00 00000000 1 1 22 4 00000005 00000007 07 1 1
0 01cf682a ffffffff 00000000 0 00 00000000 0 00 00000000 1 1 2a 4 ffffffff 00000000 0d 1 1
// forwarding priority
0 00841820 11111111 22222222 1 04 eeeeeeee 1 04 cccccccc 1 1 20 4 eeeeeeee eeeeeeee 03 1 1
0 00841820 11111111 22222222 1 05 eeeeeeee 1 04 cccccccc 1 1 20 4 cccccccc cccccccc 03 1 1
0 00841820 11111111 22222222 0 04 eeeeeeee 0 04 cccccccc 1 1 20 4 11111111 22222222 03 1 1
0 00430825 11111111 22222222 1 03 eeeeeeee 1 02 cccccccc 1 1 25 1 cccccccc eeeeeeee 01 1 1
1 34238001 00000000 00000000 1 01 0badf00d 1 01 cccccccc 1 0 25 1 00000000 00008001 03 1 1
// moves, sync, pref, unknown opcode
0 00c7280b 12345678 00000000 0 00 00000000 1 07 00000009 1 1 0b 3 12345678 00000009 05 1 1
0 00c7280b 12345678 00000000 0 00 00000000 0 00 00000000 1 1 0b 3 12345678 00000000 05 0 1
0 00c7280a 12345678 00000001 1 07 00000000 0 00 00000000 1 1 0a 3 12345678 00000000 05 1 1
0 00c7280a 12345678 00000001 0 00 00000000 0 00 00000000 1 1 0a 3 12345678 00000001 05 0 1
0 0000000f 11111111 22222222 0 00 00000000 0 00 00000000 0 0 00 0 00000000 00000000 00 0 1
0 cc810010 11111111 22222222 0 00 00000000 0 00 00000000 0 0 00 0 00000000 00000000 00 0 1
0 8c430004 11111111 22222222 0 00 00000000 0 00 00000000 0 0 00 0 00000000 00000000 00 0 0

// File: id_stage.f
rtl/id_pkg.sv
rtl/inst_decode.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
bench/tb_clock.sv
bench/id_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= id_stage_tb
FILELIST  ?= id_stage.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# decode feeds rt back from operand select, so the build keeps going on warnings
sim:
	$(VERILATOR) --binary -Wno-fatal $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
